/* Makefile */
TOP = interp_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* filelist.f */
rtl/interp_pkg.sv
rtl/mem_port_if.sv
rtl/serial_divider.sv
rtl/slope_engine.sv
rtl/eval_engine.sv
rtl/phase_scheduler.sv
rtl/interp_top.sv
verif/interp_sva.sv
verif/interp_tb.sv

/* rtl/eval_engine.sv */
`timescale 1ns/1ps

module eval_engine #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 13
) (
  input  logic       CLK,
  input  logic       RST,
  input  logic       go,
  output logic       finished,
  mem_port_if.engine mem
);

  import interp_pkg::*;

  eval_state_t           state;
  elem_cnt_t             idx;
  elem_cnt_t             cnt;
  logic                  hdr_step;
  logic [DATA_WIDTH-1:0] elapsed;
  logic [DATA_WIDTH-1:0] result;

  always_comb
  begin
    mem.rd1_addr = ADDR_WIDTH'(COUNT_ADDR);
    mem.rd2_addr = ADDR_WIDTH'(TIME_NOW_ADDR);
    mem.wr_en    = 1'b0;
    mem.wr_addr  = ADDR_WIDTH'(RESULT_BASE) + ADDR_WIDTH'(idx);
    mem.wr_data  = result;
    case (state)
      EV_LATCH_TIMES:
        mem.rd1_addr = ADDR_WIDTH'(T_OLD_ADDR);
      EV_RD_ELEM:
      begin
        mem.rd1_addr = ADDR_WIDTH'(SLOPE_BASE) + ADDR_WIDTH'(idx);
        mem.rd2_addr = ADDR_WIDTH'(U_OLD_BASE) + ADDR_WIDTH'(idx);
      end
      EV_WRITE:
        mem.wr_en = 1'b1;
      default:
        mem.wr_en = 1'b0;
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state    <= EV_IDLE;
      idx      <= '0;
      hdr_step <= 1'b0;
      finished <= 1'b0;
    end
    else
    begin
      finished <= 1'b0;
      case (state)
        EV_IDLE:
          if (go)
          begin
            state <= EV_RD_TIMES;
          end
        EV_RD_TIMES:
          state <= EV_LATCH_TIMES;
        EV_LATCH_TIMES:
          if (!hdr_step)
          begin
            hdr_step <= 1'b1;
          end
          else
          begin
            hdr_step <= 1'b0;
            idx      <= '0;
            if (cnt == '0)
            begin
              finished <= 1'b1;
              state    <= EV_IDLE;
            end
            else
            begin
              state <= EV_RD_ELEM;
            end
          end
        EV_RD_ELEM:
          state <= EV_LATCH_ELEM;
        EV_LATCH_ELEM:
          state <= EV_WRITE;
        EV_WRITE:
        begin
          idx <= idx + 1'b1;
          if (elem_cnt_t'(idx + 1'b1) == cnt)
          begin
            finished <= 1'b1;
            state    <= EV_IDLE;
          end
          else
          begin
            state <= EV_RD_ELEM;
          end
        end
        default:
          state <= EV_IDLE;
      endcase
    end
  end

  // own copy of the count, elapsed time is t_now - t_old.
  always_ff @(posedge CLK)
  begin
    if (state == EV_LATCH_TIMES && !hdr_step)
    begin
      cnt     <= (mem.rd1_data > DATA_WIDTH'(MAX_ELEMS)) ?
                 elem_cnt_t'(MAX_ELEMS) : elem_cnt_t'(mem.rd1_data);
      elapsed <= mem.rd2_data;
    end
    else if (state == EV_LATCH_TIMES)
    begin
      elapsed <= elapsed - mem.rd1_data;
    end
    if (state == EV_LATCH_ELEM)
    begin
      result <= mem.rd2_data + mem.rd1_data * elapsed;
    end
  end

endmodule

/* rtl/interp_pkg.sv */
package interp_pkg;

  // fixed header words.
  localparam int TIME_NOW_ADDR = 1;
  localparam int COUNT_ADDR    = 2;
  localparam int T_OLD_ADDR    = 3;
  localparam int T_NEW_ADDR    = 4;

  // table bases, element i at base + i.
  localparam int U_OLD_BASE  = 53;
  localparam int U_NEW_BASE  = 103;
  localparam int SLOPE_BASE  = 353;
  localparam int RESULT_BASE = 403;

  localparam int MAX_ELEMS = 8;

  typedef logic [3:0] elem_cnt_t;

  typedef enum logic [2:0] {
    SL_IDLE,
    SL_RD_HDR,
    SL_LATCH_HDR,
    SL_RD_ELEM,
    SL_LATCH_ELEM,
    SL_DIVIDE,
    SL_WRITE
  } slope_state_t;

  typedef enum logic [2:0] {
    EV_IDLE,
    EV_RD_TIMES,
    EV_LATCH_TIMES,
    EV_RD_ELEM,
    EV_LATCH_ELEM,
    EV_WRITE
  } eval_state_t;

endpackage

/* rtl/interp_top.sv */
`timescale 1ns/1ps

module interp_top #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 13
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  init_start,
  input  logic                  interp_start,
  output logic [ADDR_WIDTH-1:0] rd1_addr,
  output logic [ADDR_WIDTH-1:0] rd2_addr,
  input  logic [DATA_WIDTH-1:0] rd1_data,
  input  logic [DATA_WIDTH-1:0] rd2_data,
  output logic                  wr_en,
  output logic [ADDR_WIDTH-1:0] wr_addr,
  output logic [DATA_WIDTH-1:0] wr_data,
  output logic                  init_done,
  output logic                  interp_done,
  output logic                  error
);

  logic                  slope_go;
  logic                  eval_go;
  logic                  slope_finished;
  logic                  slope_fault;
  logic                  eval_finished;
  logic                  div_start;
  logic                  div_done;
  logic                  div_zero;
  logic [DATA_WIDTH-1:0] dividend;
  logic [DATA_WIDTH-1:0] divisor;
  logic [DATA_WIDTH-1:0] quotient;

  mem_port_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) slope_port ();
  mem_port_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) eval_port ();

  serial_divider #(.DATA_WIDTH(DATA_WIDTH)) div_i (
    .CLK      (CLK),
    .RST      (RST),
    .start    (div_start),
    .dividend (dividend),
    .divisor  (divisor),
    .done     (div_done),
    .quotient (quotient),
    .div_zero (div_zero)
  );

  slope_engine #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) slope_i (
    .CLK       (CLK),
    .RST       (RST),
    .go        (slope_go),
    .finished  (slope_finished),
    .fault     (slope_fault),
    .div_start (div_start),
    .dividend  (dividend),
    .divisor   (divisor),
    .div_done  (div_done),
    .div_zero  (div_zero),
    .quotient  (quotient),
    .mem       (slope_port.engine)
  );

  eval_engine #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) eval_i (
    .CLK      (CLK),
    .RST      (RST),
    .go       (eval_go),
    .finished (eval_finished),
    .mem      (eval_port.engine)
  );

  phase_scheduler #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) sched_i (
    .CLK            (CLK),
    .RST            (RST),
    .init_start     (init_start),
    .interp_start   (interp_start),
    .slope_finished (slope_finished),
    .slope_fault    (slope_fault),
    .eval_finished  (eval_finished),
    .slope_go       (slope_go),
    .eval_go        (eval_go),
    .init_done      (init_done),
    .interp_done    (interp_done),
    .error          (error),
    .slope_port     (slope_port.sched),
    .eval_port      (eval_port.sched),
    .rd1_addr       (rd1_addr),
    .rd2_addr       (rd2_addr),
    .rd1_data       (rd1_data),
    .rd2_data       (rd2_data),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data)
  );

endmodule

/* rtl/mem_port_if.sv */
`timescale 1ns/1ps

// one engine's view of the shared memory.
interface mem_port_if #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 13
);

  logic [ADDR_WIDTH-1:0] rd1_addr;
  logic [ADDR_WIDTH-1:0] rd2_addr;
  logic [DATA_WIDTH-1:0] rd1_data;
  logic [DATA_WIDTH-1:0] rd2_data;
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;

  modport engine (
    output rd1_addr, rd2_addr, wr_en, wr_addr, wr_data,
    input  rd1_data, rd2_data
  );

  modport sched (
    input  rd1_addr, rd2_addr, wr_en, wr_addr, wr_data,
    output rd1_data, rd2_data
  );

endinterface

/* rtl/phase_scheduler.sv */
`timescale 1ns/1ps

module phase_scheduler #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 13
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  init_start,
  input  logic                  interp_start,
  input  logic                  slope_finished,
  input  logic                  slope_fault,
  input  logic                  eval_finished,
  output logic                  slope_go,
  output logic                  eval_go,
  output logic                  init_done,
  output logic                  interp_done,
  output logic                  error,
  mem_port_if.sched             slope_port,
  mem_port_if.sched             eval_port,
  output logic [ADDR_WIDTH-1:0] rd1_addr,
  output logic [ADDR_WIDTH-1:0] rd2_addr,
  input  logic [DATA_WIDTH-1:0] rd1_data,
  input  logic [DATA_WIDTH-1:0] rd2_data,
  output logic                  wr_en,
  output logic [ADDR_WIDTH-1:0] wr_addr,
  output logic [DATA_WIDTH-1:0] wr_data
);

  logic pend_init;
  logic pend_eval;
  logic running;
  logic owner_eval;
  logic req_init;
  logic req_eval;
  logic free;

  assign req_init = pend_init | init_start;
  assign req_eval = pend_eval | interp_start;
  // an engine finishing this cycle frees the ports for the next go.
  assign free = ~running | slope_finished | slope_fault | eval_finished;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      pend_init  <= 1'b0;
      pend_eval  <= 1'b0;
      running    <= 1'b0;
      owner_eval <= 1'b0;
      slope_go   <= 1'b0;
      eval_go    <= 1'b0;
      error      <= 1'b0;
    end
    else
    begin
      slope_go  <= 1'b0;
      eval_go   <= 1'b0;
      pend_init <= req_init;
      pend_eval <= req_eval;
      if (free && req_init)
      begin
        slope_go   <= 1'b1;
        running    <= 1'b1;
        owner_eval <= 1'b0;
        pend_init  <= 1'b0;
      end
      else if (free && req_eval)
      begin
        eval_go    <= 1'b1;
        running    <= 1'b1;
        owner_eval <= 1'b1;
        pend_eval  <= 1'b0;
      end
      else if (free)
      begin
        running <= 1'b0;
      end
      if (slope_fault)
      begin
        error <= 1'b1;
      end
      else if (slope_go)
      begin
        error <= 1'b0;
      end
    end
  end

  assign init_done   = slope_finished;
  assign interp_done = eval_finished;

  // read data goes to both, only the owner listens.
  assign slope_port.rd1_data = rd1_data;
  assign slope_port.rd2_data = rd2_data;
  assign eval_port.rd1_data  = rd1_data;
  assign eval_port.rd2_data  = rd2_data;

  assign rd1_addr = owner_eval ? eval_port.rd1_addr : slope_port.rd1_addr;
  assign rd2_addr = owner_eval ? eval_port.rd2_addr : slope_port.rd2_addr;
  assign wr_en    = owner_eval ? eval_port.wr_en    : slope_port.wr_en;
  assign wr_addr  = owner_eval ? eval_port.wr_addr  : slope_port.wr_addr;
  assign wr_data  = owner_eval ? eval_port.wr_data  : slope_port.wr_data;

endmodule

/* rtl/serial_divider.sv */
`timescale 1ns/1ps

module serial_divider #(
  parameter int DATA_WIDTH = 16
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  logic [DATA_WIDTH-1:0] dividend,
  input  logic [DATA_WIDTH-1:0] divisor,
  output logic                  done,
  output logic [DATA_WIDTH-1:0] quotient,
  output logic                  div_zero
);

  localparam int CNT_W = $clog2(DATA_WIDTH + 1);

  logic [CNT_W-1:0]      step_cnt;
  logic                  busy;
  logic [DATA_WIDTH-1:0] rem_q;
  logic [DATA_WIDTH-1:0] quo_q;
  logic [DATA_WIDTH-1:0] dvs_q;
  logic [DATA_WIDTH:0]   rem_shift;
  logic [DATA_WIDTH:0]   rem_trial;
  logic                  fits;

  // shift in the next dividend bit, then trial subtract.
  assign rem_shift = {rem_q, quo_q[DATA_WIDTH-1]};
  assign rem_trial = rem_shift - {1'b0, dvs_q};
  assign fits      = ~rem_trial[DATA_WIDTH];

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      busy     <= 1'b0;
      done     <= 1'b0;
      step_cnt <= '0;
    end
    else
    begin
      done <= 1'b0;
      if (start)
      begin
        busy     <= 1'b1;
        step_cnt <= CNT_W'(DATA_WIDTH);
      end
      else if (busy)
      begin
        step_cnt <= step_cnt - 1'b1;
        if (step_cnt == CNT_W'(1))
        begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (start)
    begin
      rem_q <= '0;
      quo_q <= dividend;
      dvs_q <= divisor;
    end
    else if (busy)
    begin
      rem_q <= fits ? rem_trial[DATA_WIDTH-1:0] : rem_shift[DATA_WIDTH-1:0];
      quo_q <= {quo_q[DATA_WIDTH-2:0], fits};
    end
  end

  // a zero divisor always subtracts, so the quotient ends up all ones.
  assign quotient = quo_q;
  assign div_zero = done & (dvs_q == '0);

endmodule

/* rtl/slope_engine.sv */
`timescale 1ns/1ps

module slope_engine #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 13
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  go,
  output logic                  finished,
  output logic                  fault,
  output logic                  div_start,
  output logic [DATA_WIDTH-1:0] dividend,
  output logic [DATA_WIDTH-1:0] divisor,
  input  logic                  div_done,
  input  logic                  div_zero,
  input  logic [DATA_WIDTH-1:0] quotient,
  mem_port_if.engine            mem
);

  import interp_pkg::*;

  slope_state_t state;
  elem_cnt_t    idx;
  elem_cnt_t    cnt;
  logic         hdr_step;

  always_comb
  begin
    mem.rd1_addr = ADDR_WIDTH'(COUNT_ADDR);
    mem.rd2_addr = ADDR_WIDTH'(T_NEW_ADDR);
    mem.wr_en    = 1'b0;
    mem.wr_addr  = ADDR_WIDTH'(SLOPE_BASE) + ADDR_WIDTH'(idx);
    mem.wr_data  = quotient;
    case (state)
      SL_LATCH_HDR:
        mem.rd1_addr = ADDR_WIDTH'(T_OLD_ADDR);
      SL_RD_ELEM:
      begin
        mem.rd1_addr = ADDR_WIDTH'(U_OLD_BASE) + ADDR_WIDTH'(idx);
        mem.rd2_addr = ADDR_WIDTH'(U_NEW_BASE) + ADDR_WIDTH'(idx);
      end
      SL_WRITE:
        mem.wr_en = 1'b1;
      default:
        mem.wr_en = 1'b0;
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state     <= SL_IDLE;
      idx       <= '0;
      hdr_step  <= 1'b0;
      finished  <= 1'b0;
      fault     <= 1'b0;
      div_start <= 1'b0;
    end
    else
    begin
      finished  <= 1'b0;
      fault     <= 1'b0;
      div_start <= 1'b0;
      case (state)
        SL_IDLE:
          if (go)
          begin
            state <= SL_RD_HDR;
          end
        SL_RD_HDR:
          state <= SL_LATCH_HDR;
        SL_LATCH_HDR:
          if (!hdr_step)
          begin
            hdr_step <= 1'b1;
          end
          else
          begin
            hdr_step <= 1'b0;
            idx      <= '0;
            if (cnt == '0)
            begin
              finished <= 1'b1;
              state    <= SL_IDLE;
            end
            else
            begin
              state <= SL_RD_ELEM;
            end
          end
        SL_RD_ELEM:
          state <= SL_LATCH_ELEM;
        SL_LATCH_ELEM:
        begin
          div_start <= 1'b1;
          state     <= SL_DIVIDE;
        end
        SL_DIVIDE:
          if (div_done)
          begin
            if (div_zero)
            begin
              // abandon the table, no finished pulse.
              fault <= 1'b1;
              state <= SL_IDLE;
            end
            else
            begin
              state <= SL_WRITE;
            end
          end
        SL_WRITE:
        begin
          idx <= idx + 1'b1;
          if (elem_cnt_t'(idx + 1'b1) == cnt)
          begin
            finished <= 1'b1;
            state    <= SL_IDLE;
          end
          else
          begin
            state <= SL_RD_ELEM;
          end
        end
        default:
          state <= SL_IDLE;
      endcase
    end
  end

  // header arrives in two steps: count and t_new, then t_old.
  always_ff @(posedge CLK)
  begin
    if (state == SL_LATCH_HDR && !hdr_step)
    begin
      cnt     <= (mem.rd1_data > DATA_WIDTH'(MAX_ELEMS)) ?
                 elem_cnt_t'(MAX_ELEMS) : elem_cnt_t'(mem.rd1_data);
      divisor <= mem.rd2_data;
    end
    else if (state == SL_LATCH_HDR)
    begin
      divisor <= divisor - mem.rd1_data;
    end
    if (state == SL_LATCH_ELEM)
    begin
      dividend <= mem.rd2_data - mem.rd1_data;
    end
  end

endmodule

/* verif/interp_sva.sv */
`timescale 1ns/1ps

// protocol checks on the top-level outputs.
module interp_sva #(
  parameter int ADDR_WIDTH = 13
) (
  input logic                  CLK,
  input logic                  RST,
  input logic                  wr_en,
  input logic [ADDR_WIDTH-1:0] wr_addr,
  input logic                  init_done,
  input logic                  interp_done,
  input logic                  error
);

  import interp_pkg::*;

  int fail_cnt = 0;
  int slot;
  logic in_tables;

  assign slot      = int'(wr_addr);
  assign in_tables = (slot >= SLOPE_BASE && slot < SLOPE_BASE + MAX_ELEMS) ||
                     (slot >= RESULT_BASE && slot < RESULT_BASE + MAX_ELEMS);

  // everything quiet right after a reset cycle.
  reset_quiet: assert property (@(posedge CLK)
    !RST |=> (!wr_en && !init_done && !interp_done && !error))
  else
  begin
    $error("outputs active after reset");
    fail_cnt++;
  end

  init_done_single: assert property (@(posedge CLK) disable iff (!RST)
    init_done |=> !init_done)
  else
  begin
    $error("init_done high for two cycles");
    fail_cnt++;
  end

  interp_done_single: assert property (@(posedge CLK) disable iff (!RST)
    interp_done |=> !interp_done)
  else
  begin
    $error("interp_done high for two cycles");
    fail_cnt++;
  end

  done_exclusive: assert property (@(posedge CLK) disable iff (!RST)
    !(init_done && interp_done))
  else
  begin
    $error("init_done and interp_done high together");
    fail_cnt++;
  end

  write_in_tables: assert property (@(posedge CLK) disable iff (!RST)
    wr_en |-> in_tables)
  else
  begin
    $error("write outside the slope and result tables");
    fail_cnt++;
  end

endmodule

bind interp_top interp_sva #(.ADDR_WIDTH(ADDR_WIDTH)) sva_i (
  .CLK         (CLK),
  .RST         (RST),
  .wr_en       (wr_en),
  .wr_addr     (wr_addr),
  .init_done   (init_done),
  .interp_done (interp_done),
  .error       (error)
);

/* verif/interp_tb.sv */
`timescale 1ns/1ps

module interp_tb;

  import interp_pkg::*;

  localparam int DATA_WIDTH = 16;
  localparam int ADDR_WIDTH = 13;
  localparam int CLK_PERIOD = 8;
  // one run: divider-bound elements, header and table loading.
  localparam int RUN_CYCLES = MAX_ELEMS * (DATA_WIDTH + 8) + 4 * MAX_ELEMS + 32;
  localparam int NUM_RUNS   = 22;

  logic                  CLK = 1'b0;
  logic                  RST = 1'b0;
  logic                  init_start = 1'b0;
  logic                  interp_start = 1'b0;
  logic [ADDR_WIDTH-1:0] rd1_addr;
  logic [ADDR_WIDTH-1:0] rd2_addr;
  logic [DATA_WIDTH-1:0] rd1_data = '0;
  logic [DATA_WIDTH-1:0] rd2_data = '0;
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  init_done;
  logic                  interp_done;
  logic                  error;
  logic                  ld_en = 1'b0;
  logic [ADDR_WIDTH-1:0] ld_addr = '0;
  logic [DATA_WIDTH-1:0] ld_data = '0;

  logic [DATA_WIDTH-1:0] mem [0:(1 << ADDR_WIDTH) - 1];
  logic [DATA_WIDTH-1:0] u_old_v [MAX_ELEMS];
  logic [DATA_WIDTH-1:0] u_new_v [MAX_ELEMS];
  logic [DATA_WIDTH-1:0] exp_slope [MAX_ELEMS];
  logic [DATA_WIDTH-1:0] exp_result [MAX_ELEMS];
  logic [31:0]           rng_state = 32'heb10c7ca;
  int exp_cnt = 0;
  int init_dones = 0;
  int interp_dones = 0;
  int slope_writes = 0;
  int result_writes = 0;
  int mon_errors = 0;
  int seq_errors = 0;
  int passed = 0;
  int failed = 0;

  interp_top #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) dut_i (
    .CLK          (CLK),
    .RST          (RST),
    .init_start   (init_start),
    .interp_start (interp_start),
    .rd1_addr     (rd1_addr),
    .rd2_addr     (rd2_addr),
    .rd1_data     (rd1_data),
    .rd2_data     (rd2_data),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .init_done    (init_done),
    .interp_done  (interp_done),
    .error        (error)
  );

  initial
  begin
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // registered reads, loader port for the test data.
  always @(posedge CLK)
  begin
    if (ld_en)
      mem[ld_addr] <= ld_data;
    else if (wr_en)
      mem[wr_addr] <= wr_data;
    rd1_data <= mem[rd1_addr];
    rd2_data <= mem[rd2_addr];
  end

  always @(posedge CLK)
  begin
    int slot;
    slot = int'(wr_addr);
    if (RST && init_done)
      init_dones <= init_dones + 1;
    if (RST && interp_done)
      interp_dones <= interp_dones + 1;
    if (RST && wr_en)
    begin
      if (slot >= SLOPE_BASE && slot < SLOPE_BASE + MAX_ELEMS)
      begin
        slope_writes <= slope_writes + 1;
        assert (wr_data == exp_slope[slot - SLOPE_BASE])
        else
        begin
          $error("mismatch at %0t: slope[%0d] is %h, expected %h", $time,
                 slot - SLOPE_BASE, wr_data, exp_slope[slot - SLOPE_BASE]);
          mon_errors <= mon_errors + 1;
        end
      end
      else if (slot >= RESULT_BASE && slot < RESULT_BASE + MAX_ELEMS)
      begin
        result_writes <= result_writes + 1;
        assert (wr_data == exp_result[slot - RESULT_BASE])
        else
        begin
          $error("mismatch at %0t: result[%0d] is %h, expected %h", $time,
                 slot - RESULT_BASE, wr_data, exp_result[slot - RESULT_BASE]);
          mon_errors <= mon_errors + 1;
        end
      end
      else
      begin
        $error("write to address %0d outside both tables at %0t", slot, $time);
        mon_errors <= mon_errors + 1;
      end
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state[DATA_WIDTH-1:0];
  endfunction

  function automatic int error_total();
    return mon_errors + seq_errors + dut_i.sva_i.fail_cnt;
  endfunction

  // slopes and results straight from the interpolation rules, all mod 2^16.
  function automatic void compute_expected(input logic [DATA_WIDTH-1:0] dt,
                                           input logic [DATA_WIDTH-1:0] elapsed);
    logic [DATA_WIDTH-1:0] diff;
    for (int i = 0; i < MAX_ELEMS; i++)
    begin
      diff          = u_new_v[i] - u_old_v[i];
      exp_slope[i]  = diff / dt;
      exp_result[i] = u_old_v[i] + exp_slope[i] * elapsed;
    end
  endfunction

  task automatic expect_ok(input bit ok, input string msg);
    assert (ok)
    else
    begin
      $error("%s", msg);
      seq_errors++;
    end
  endtask

  task automatic poke(input int addr, input logic [DATA_WIDTH-1:0] data);
    @(posedge CLK);
    ld_en   <= 1'b1;
    ld_addr <= ADDR_WIDTH'(addr);
    ld_data <= data;
  endtask

  task automatic make_case(input int stored_cnt, input bit zero_dt);
    logic [DATA_WIDTH-1:0] dt;
    logic [DATA_WIDTH-1:0] t_old;
    logic [DATA_WIDTH-1:0] t_now;
    t_old   = next_rand();
    dt      = zero_dt ? '0 : DATA_WIDTH'(1 + next_rand() % 64);
    t_now   = t_old + DATA_WIDTH'(next_rand() % 512);
    exp_cnt = (stored_cnt > MAX_ELEMS) ? MAX_ELEMS : stored_cnt;
    poke(COUNT_ADDR, DATA_WIDTH'(stored_cnt));
    poke(T_OLD_ADDR, t_old);
    poke(T_NEW_ADDR, t_old + dt);
    poke(TIME_NOW_ADDR, t_now);
    for (int i = 0; i < MAX_ELEMS; i++)
    begin
      u_old_v[i] = next_rand();
      u_new_v[i] = next_rand();
      poke(U_OLD_BASE + i, u_old_v[i]);
      poke(U_NEW_BASE + i, u_new_v[i]);
    end
    @(posedge CLK);
    ld_en <= 1'b0;
    if (!zero_dt)
      compute_expected(dt, t_now - t_old);
  endtask

  task automatic pulse_start(input bit init);
    @(posedge CLK);
    if (init)
      init_start <= 1'b1;
    else
      interp_start <= 1'b1;
    @(posedge CLK);
    init_start   <= 1'b0;
    interp_start <= 1'b0;
  endtask

  task automatic end_test(input string name, input int errors_before);
    if (error_total() == errors_before)
    begin
      passed++;
      $display("%s: ok", name);
    end
    else
    begin
      failed++;
      $display("%s: FAILED", name);
    end
  endtask

  task automatic run_phase(input bit init, input string name);
    int e0;
    int d0;
    int s0;
    int r0;
    int own;
    int other;
    e0 = error_total();
    d0 = init ? init_dones : interp_dones;
    s0 = slope_writes;
    r0 = result_writes;
    pulse_start(init);
    while ((init ? init_dones : interp_dones) == d0)
      @(posedge CLK);
    own   = init ? slope_writes - s0 : result_writes - r0;
    other = init ? result_writes - r0 : slope_writes - s0;
    expect_ok(own == exp_cnt, $sformatf("mismatch at %0t: %0d table writes, expected %0d",
                                        $time, own, exp_cnt));
    expect_ok(other == 0, $sformatf("%s wrote into the other table", name));
    expect_ok(!error, $sformatf("error output high after %s", name));
    end_test(name, e0);
  endtask

  initial
  begin
    int e0;
    int d0;
    int i0;
    int s0;
    int r0;
    repeat (2) @(posedge CLK);
    RST <= 1'b1;
    // the largest count is stored above the limit and must clamp.
    for (int k = 0; k <= MAX_ELEMS; k++)
    begin
      make_case((k == MAX_ELEMS) ? k + 4 : k, 1'b0);
      run_phase(1'b1, $sformatf("init, count %0d", k));
      run_phase(1'b0, $sformatf("interp, count %0d", k));
    end

    e0 = error_total();
    d0 = init_dones;
    s0 = slope_writes;
    make_case(3, 1'b1);
    pulse_start(1'b1);
    while (!error)
      @(posedge CLK);
    make_case(5, 1'b0);
    expect_ok(error, "error dropped before the next init start");
    expect_ok(init_dones == d0, "init_done pulsed despite a zero time difference");
    expect_ok(slope_writes == s0, "slope table written despite a zero time difference");
    end_test("zero time difference", e0);
    run_phase(1'b1, "init after error");

    // interp requested mid-init must wait and see the new slopes.
    make_case(6, 1'b0);
    e0 = error_total();
    d0 = init_dones;
    i0 = interp_dones;
    s0 = slope_writes;
    r0 = result_writes;
    pulse_start(1'b1);
    repeat (2) @(posedge CLK);
    pulse_start(1'b0);
    while (init_dones == d0)
      @(posedge CLK);
    expect_ok(result_writes == r0, "result table written during initialization");
    expect_ok(interp_dones == i0, "interp_done came before init_done");
    while (interp_dones == i0)
      @(posedge CLK);
    expect_ok(slope_writes - s0 == exp_cnt, $sformatf("mismatch at %0t: %0d slope writes",
                                                      $time, slope_writes - s0));
    expect_ok(result_writes - r0 == exp_cnt, $sformatf("mismatch at %0t: %0d result writes",
                                                       $time, result_writes - r0));
    end_test("overlapping starts", e0);

    repeat (4) @(posedge CLK);
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             passed + failed, passed, failed, error_total());
    if (failed == 0 && error_total() == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    #(NUM_RUNS * RUN_CYCLES * CLK_PERIOD);
    $display("timeout: tests still running after %0d ns", NUM_RUNS * RUN_CYCLES * CLK_PERIOD);
    $display("Test failed");
    $finish;
  end

endmodule
